// File: hw/ib_cfg_pkg.sv
// ==========================================================================
// Issue-buffer configuration package
// Sizing of the slot bundle, the issue queues and the sequence tags,
// plus the functional-unit class selector
// ==========================================================================
`default_nettype none

package ib_cfg_pkg;

    // Slots per bundle, also push lanes per queue
    localparam int IS_NUM = 2;

    // Entries per issue queue
    localparam int IB_DEPTH = 8;
    // Occupancy count must hold IB_DEPTH itself
    localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);
    // Circular pointers, depth is a power of two
    localparam int IB_PTR_W = $clog2(IB_DEPTH);

    // Age tag, compared with wrap-around
    localparam int SEQ_W = 6;

    // Functional-unit class, router parameter and issue class code
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_sel_e;

endpackage : ib_cfg_pkg

`default_nettype wire

// File: hw/ib_inst_pkg.sv
// ==========================================================================
// Instruction payload package
// Packed issue payload carried through routers, queues and arbiter,
// and the wrap-around age compare on sequence tags
// ==========================================================================
`default_nettype none

package ib_inst_pkg;

    import ib_cfg_pkg::*;

    // Field widths of the payload
    localparam int OPCODE_W   = 8;
    localparam int DEST_TAG_W = 6;
    localparam int SRC_W      = 13;

    // ======================================================================
    // Issue payload, 46 bits
    // ======================================================================
    typedef struct packed {
        // Age tag, assigned in program order
        logic [SEQ_W-1:0]      seq;
        logic [OPCODE_W-1:0]   opcode;
        // Physical destination tag
        logic [DEST_TAG_W-1:0] dest_tag;
        // Source operands
        logic [SRC_W-1:0]      src_a;
        logic [SRC_W-1:0]      src_b;
    } is_inst_t;

    // ======================================================================
    // Age compare
    // ======================================================================
    // True when seq_a is older than seq_b
    // Negative wrapped difference means seq_a came first,
    // valid while at most half the tag range is in flight
    function automatic logic seq_older(
        input logic [SEQ_W-1:0] seq_a,
        input logic [SEQ_W-1:0] seq_b
    );
        logic [SEQ_W-1:0] diff;
        diff = seq_a - seq_b;
        return diff[SEQ_W-1];
    endfunction

endpackage : ib_inst_pkg

`default_nettype wire

// File: hw/ib_push_router.sv
// ==========================================================================
// Issue-buffer push-in router
// Picks the slots of one functional-unit class out of the bundle and
// packs them, in slot order, onto the lowest push lanes of its queue
// ==========================================================================
`default_nettype none

module ib_push_router
    import ib_cfg_pkg::*;
    import ib_inst_pkg::*;
#(
    parameter fu_sel_e C_FU_TYPE = FU_ALU
) (
    // Slot bundle from the reservation station
    input  logic     [IS_NUM-1:0] rs_valid_i,
    input  logic     [IS_NUM-1:0] rs_alu_i,
    input  logic     [IS_NUM-1:0] rs_mult_i,
    input  is_inst_t [IS_NUM-1:0] rs_inst_i,
    // Bundle taken this cycle by both routers
    input  logic                  accept_i,
    output logic                  ready_o,
    // Push lanes into the issue queue
    output logic     [IS_NUM-1:0] m_valid_o,
    input  logic     [IS_NUM-1:0] m_ready_i,
    output is_inst_t [IS_NUM-1:0] m_inst_o
);

    // Class bit of each slot for this router
    logic [IS_NUM-1:0] class_bit;
    // Slots that belong to this router
    logic [IS_NUM-1:0] sel_valid;

    // ======================================================================
    // Queue readiness
    // ======================================================================
    // Worst case every slot lands here, so all lanes must be free
    assign ready_o = &m_ready_i;

    // ======================================================================
    // Class select
    // ======================================================================
    assign class_bit = (C_FU_TYPE == FU_MULT) ? rs_mult_i : rs_alu_i;
    assign sel_valid = rs_valid_i & class_bit;

    // ======================================================================
    // Compaction onto push lanes
    // ======================================================================
    always_comb begin
        int lane;
        lane      = 0;
        m_valid_o = '0;
        m_inst_o  = '0;
        // Walk slots in order, next selected slot takes next free lane
        for (int s = 0; s < IS_NUM; s++) begin
            if (sel_valid[s]) begin
                // Lanes only push on an accepted bundle
                m_valid_o[lane] = accept_i;
                m_inst_o[lane]  = rs_inst_i[s];
                lane++;
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // Each valid slot of an accepted bundle names exactly one class
    always_comb begin
        if (accept_i) begin
            a_one_class : assert ((rs_valid_i & ~(rs_alu_i ^ rs_mult_i)) == '0)
                else $error("slot with zero or two class bits");
        end
    end

endmodule : ib_push_router

`default_nettype wire

// File: hw/ib_queue.sv
// ==========================================================================
// Issue-buffer queue
// Circular buffer taking up to IS_NUM pushes per cycle at consecutive
// entries and handing out one head per cycle
// ==========================================================================
`default_nettype none

module ib_queue
    import ib_cfg_pkg::*;
    import ib_inst_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Push lanes, valid lanes form a prefix from lane 0
    input  logic     [IS_NUM-1:0] push_valid_i,
    input  is_inst_t [IS_NUM-1:0] push_inst_i,
    output logic     [IS_NUM-1:0] push_ready_o,
    // Head port
    output logic                  head_valid_o,
    output is_inst_t              head_inst_o,
    input  logic                  pop_i
);

    // Entry storage
    is_inst_t mem [IB_DEPTH];

    // Pointers and occupancy
    logic [IB_PTR_W-1:0] wr_ptr_q;
    logic [IB_PTR_W-1:0] rd_ptr_q;
    logic [IB_CNT_W-1:0] cnt_q;

    logic [IB_CNT_W-1:0] free_cnt;
    logic [IB_CNT_W-1:0] push_num;
    logic                pop_fire;

    // ======================================================================
    // Space and head
    // ======================================================================
    // Registered count only, a pop frees room from next cycle
    assign free_cnt = IB_CNT_W'(IB_DEPTH) - cnt_q;

    always_comb begin
        for (int k = 0; k < IS_NUM; k++) begin
            // Lane k needs k+1 free entries
            push_ready_o[k] = (free_cnt > IB_CNT_W'(k));
        end
    end

    assign head_valid_o = (cnt_q != '0);
    assign head_inst_o  = mem[rd_ptr_q];
    assign pop_fire     = pop_i & head_valid_o;

    // Number of lanes pushing this cycle
    always_comb begin
        push_num = '0;
        for (int k = 0; k < IS_NUM; k++) begin
            push_num = push_num + IB_CNT_W'(push_valid_i[k]);
        end
    end

    // ======================================================================
    // Storage write
    // ======================================================================
    // Lane k goes k entries past the write pointer, wrap is free
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < IS_NUM; k++) begin
            if (push_valid_i[k]) begin
                mem[wr_ptr_q + IB_PTR_W'(k)] <= push_inst_i[k];
            end
        end
    end

    // ======================================================================
    // Pointer and count update
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + IB_PTR_W'(push_num);
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + push_num - IB_CNT_W'(pop_fire);
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // Router gating must keep pushes within registered free space
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_num <= free_cnt);

    // Arbiter pops only a valid head
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> head_valid_o);

    a_cnt_bound : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cnt_q <= IB_CNT_W'(IB_DEPTH));

endmodule : ib_queue

`default_nettype wire

// File: hw/ib_issue_arbiter.sv
// ==========================================================================
// Issue arbiter
// Oldest-first merge of the ALU and multiplier queue heads into one
// registered issue port
// ==========================================================================
`default_nettype none

module ib_issue_arbiter
    import ib_cfg_pkg::*;
    import ib_inst_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Queue heads
    input  logic     alu_valid_i,
    input  is_inst_t alu_inst_i,
    output logic     alu_pop_o,
    input  logic     mult_valid_i,
    input  is_inst_t mult_inst_i,
    output logic     mult_pop_o,
    // Issue port
    output logic     iss_valid_o,
    output fu_sel_e  iss_fu_o,
    output is_inst_t iss_inst_o,
    input  logic     iss_ready_i
);

    logic load_en;
    logic pick_mult;

    // Output register empty or draining this edge
    assign load_en = !iss_valid_o || iss_ready_i;

    // Multiplier wins when alone or older
    assign pick_mult = mult_valid_i &&
                       (!alu_valid_i || seq_older(mult_inst_i.seq, alu_inst_i.seq));

    assign alu_pop_o  = load_en && alu_valid_i && !pick_mult;
    assign mult_pop_o = load_en && pick_mult;

    // ======================================================================
    // Output register
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_valid_o <= 1'b0;
            iss_fu_o    <= FU_ALU;
        end else if (load_en) begin
            iss_valid_o <= alu_pop_o || mult_pop_o;
            iss_fu_o    <= pick_mult ? FU_MULT : FU_ALU;
        end
    end

    // Payload follows the winning head
    always_ff @(posedge clk_i) begin
        if (load_en) begin
            iss_inst_o <= pick_mult ? mult_inst_i : alu_inst_i;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // Head tags differ and are not half the tag range apart
    a_age_order : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (alu_valid_i && mult_valid_i) |->
            (seq_older(alu_inst_i.seq, mult_inst_i.seq) !=
             seq_older(mult_inst_i.seq, alu_inst_i.seq)));

endmodule : ib_issue_arbiter

`default_nettype wire

// File: hw/ib_top.sv
// ==========================================================================
// Issue-buffer front end
// Two class routers feed two issue queues, merged oldest-first
// ==========================================================================
`default_nettype none

module ib_top
    import ib_cfg_pkg::*;
    import ib_inst_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Reservation station bundle
    input  logic     [IS_NUM-1:0] rs_valid_i,
    input  logic     [IS_NUM-1:0] rs_alu_i,
    input  logic     [IS_NUM-1:0] rs_mult_i,
    input  is_inst_t [IS_NUM-1:0] rs_inst_i,
    output logic                  rs_ready_o,
    // Issue port
    output logic                  iss_valid_o,
    output fu_sel_e               iss_fu_o,
    output is_inst_t              iss_inst_o,
    input  logic                  iss_ready_i
);

    // ALU path
    logic                  alu_rdy;
    logic     [IS_NUM-1:0] alu_push_valid;
    logic     [IS_NUM-1:0] alu_push_ready;
    is_inst_t [IS_NUM-1:0] alu_push_inst;
    logic                  alu_head_valid;
    is_inst_t              alu_head_inst;
    logic                  alu_pop;

    // Multiplier path
    logic                  mult_rdy;
    logic     [IS_NUM-1:0] mult_push_valid;
    logic     [IS_NUM-1:0] mult_push_ready;
    is_inst_t [IS_NUM-1:0] mult_push_inst;
    logic                  mult_head_valid;
    is_inst_t              mult_head_inst;
    logic                  mult_pop;

    // Bundle taken only when both queues have room
    assign rs_ready_o = alu_rdy & mult_rdy;

    // ======================================================================
    // Routers
    // ======================================================================
    ib_push_router #(.C_FU_TYPE(FU_ALU)) u_alu_router (
        .rs_valid_i(rs_valid_i), .rs_alu_i(rs_alu_i), .rs_mult_i(rs_mult_i),
        .rs_inst_i(rs_inst_i), .accept_i(rs_ready_o), .ready_o(alu_rdy),
        .m_valid_o(alu_push_valid), .m_ready_i(alu_push_ready), .m_inst_o(alu_push_inst)
    );

    ib_push_router #(.C_FU_TYPE(FU_MULT)) u_mult_router (
        .rs_valid_i(rs_valid_i), .rs_alu_i(rs_alu_i), .rs_mult_i(rs_mult_i),
        .rs_inst_i(rs_inst_i), .accept_i(rs_ready_o), .ready_o(mult_rdy),
        .m_valid_o(mult_push_valid), .m_ready_i(mult_push_ready), .m_inst_o(mult_push_inst)
    );

    // ======================================================================
    // Queues
    // ======================================================================
    ib_queue u_alu_queue (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .push_valid_i(alu_push_valid), .push_inst_i(alu_push_inst),
        .push_ready_o(alu_push_ready), .head_valid_o(alu_head_valid),
        .head_inst_o(alu_head_inst), .pop_i(alu_pop)
    );

    ib_queue u_mult_queue (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .push_valid_i(mult_push_valid), .push_inst_i(mult_push_inst),
        .push_ready_o(mult_push_ready), .head_valid_o(mult_head_valid),
        .head_inst_o(mult_head_inst), .pop_i(mult_pop)
    );

    // Oldest-first issue
    ib_issue_arbiter u_arbiter (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .alu_valid_i(alu_head_valid), .alu_inst_i(alu_head_inst), .alu_pop_o(alu_pop),
        .mult_valid_i(mult_head_valid), .mult_inst_i(mult_head_inst), .mult_pop_o(mult_pop),
        .iss_valid_o(iss_valid_o), .iss_fu_o(iss_fu_o), .iss_inst_o(iss_inst_o),
        .iss_ready_i(iss_ready_i)
    );

endmodule : ib_top

`default_nettype wire

// File: tests/tb_ib_top.sv
// ==========================================================================
// Testbench for the issue-buffer front end
// Random bundles and issue back-pressure against per-class model queues,
// concurrent checks on routing, age order, stall hold and latency
// ==========================================================================
`default_nettype none

module tb_ib_top
    import ib_cfg_pkg::*;
    import ib_inst_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  arst_n;
    logic     [IS_NUM-1:0] rs_valid;
    logic     [IS_NUM-1:0] rs_alu;
    logic     [IS_NUM-1:0] rs_mult;
    is_inst_t [IS_NUM-1:0] rs_inst;
    logic                  rs_ready;
    logic                  iss_valid;
    fu_sel_e               iss_fu;
    is_inst_t              iss_inst;
    logic                  iss_ready;

    // Stimulus state
    int               seed;
    logic [SEQ_W-1:0] next_tag;
    int               stall_left;
    logic             ready_hold;
    logic             lat_arm;

    // Model queues, payload plus unwrapped acceptance age
    is_inst_t alu_q[$];
    is_inst_t mult_q[$];
    int       alu_age_q[$];
    int       mult_age_q[$];
    int       age_cnt     = 0;
    int       alu_cnt     = 0;
    int       mult_cnt    = 0;
    int       alu_age     = 0;
    int       mult_age    = 0;
    fu_sel_e  exp_fu      = FU_ALU;
    is_inst_t exp_inst    = '0;
    logic     seen_accept = 1'b0;
    int       alu_occ;
    int       mult_occ;
    logic     exp_ready;

    // Handshakes of the coming edge, taken at the falling edge
    logic                  acc_next  = 1'b0;
    logic                  iss_next  = 1'b0;
    logic     [IS_NUM-1:0] cap_valid = '0;
    logic     [IS_NUM-1:0] cap_alu   = '0;
    is_inst_t [IS_NUM-1:0] cap_inst  = '0;

    ib_top dut_i (
        .clk_i(clk), .arst_n_i(arst_n),
        .rs_valid_i(rs_valid), .rs_alu_i(rs_alu), .rs_mult_i(rs_mult),
        .rs_inst_i(rs_inst), .rs_ready_o(rs_ready),
        .iss_valid_o(iss_valid), .iss_fu_o(iss_fu), .iss_inst_o(iss_inst),
        .iss_ready_i(iss_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    always @(negedge clk) begin
        acc_next  = arst_n && rs_ready;
        iss_next  = arst_n && iss_valid && iss_ready;
        cap_valid = rs_valid;
        cap_alu   = rs_alu;
        cap_inst  = rs_inst;
    end

    always @(posedge clk) begin
        // Issued entry is the oldest one overall, pop it first
        if (iss_next && exp_fu == FU_ALU && alu_cnt > 0) begin
            void'(alu_q.pop_front());
            void'(alu_age_q.pop_front());
        end
        if (iss_next && exp_fu == FU_MULT && mult_cnt > 0) begin
            void'(mult_q.pop_front());
            void'(mult_age_q.pop_front());
        end
        // Accepted slots in lane order
        if (acc_next) begin
            for (int s = 0; s < IS_NUM; s++) begin
                if (cap_valid[s]) begin
                    seen_accept = 1'b1;
                    if (cap_alu[s]) begin
                        alu_q.push_back(cap_inst[s]);
                        alu_age_q.push_back(age_cnt);
                    end else begin
                        mult_q.push_back(cap_inst[s]);
                        mult_age_q.push_back(age_cnt);
                    end
                    age_cnt++;
                end
            end
        end
        alu_cnt  = alu_q.size();
        mult_cnt = mult_q.size();
        alu_age  = (alu_cnt > 0) ? alu_age_q[0] : 0;
        mult_age = (mult_cnt > 0) ? mult_age_q[0] : 0;
        exp_fu   = (alu_cnt > 0 && (mult_cnt == 0 || alu_age < mult_age)) ? FU_ALU : FU_MULT;
        exp_inst = '0;
        if (exp_fu == FU_ALU && alu_cnt > 0) begin
            exp_inst = alu_q[0];
        end
        if (exp_fu == FU_MULT && mult_cnt > 0) begin
            exp_inst = mult_q[0];
        end
    end

    // Queue occupancy leaves out the entry held on the issue port
    assign alu_occ   = alu_cnt - int'(iss_valid && exp_fu == FU_ALU);
    assign mult_occ  = mult_cnt - int'(iss_valid && exp_fu == FU_MULT);
    assign exp_ready = (alu_occ <= IB_DEPTH - IS_NUM) && (mult_occ <= IB_DEPTH - IS_NUM);

    // ======================================================================
    // Checks
    // ======================================================================
    a_idle_after_reset : assert property (@(posedge clk) disable iff (!arst_n)
        !seen_accept |-> (rs_ready && !iss_valid))
        else abort_run("rs_ready_o low or iss_valid_o high before the first acceptance");
    a_issue_known : assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid |-> (alu_cnt + mult_cnt) > 0)
        else abort_run("issue port valid with no matching model entry");
    a_issue_fu : assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid |-> iss_fu == exp_fu)
        else value_error("iss_fu_o", 64'($sampled(exp_fu)), 64'($sampled(iss_fu)));
    a_issue_inst : assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid |-> iss_inst == exp_inst)
        else value_error("iss_inst_o", 64'($sampled(exp_inst)), 64'($sampled(iss_inst)));
    // Both classes pending, the older acceptance goes first
    a_oldest : assert property (@(posedge clk) disable iff (!arst_n)
        (iss_valid && alu_cnt > 0 && mult_cnt > 0) |->
            iss_fu == ((alu_age < mult_age) ? FU_ALU : FU_MULT))
        else abort_run("issued instruction is not the oldest of both classes");
    a_hold : assert property (@(posedge clk) disable iff (!arst_n)
        (iss_valid && !iss_ready) |=> (iss_valid && $stable(iss_fu) && $stable(iss_inst)))
        else abort_run("issue port changed while stalled");
    a_ready_level : assert property (@(posedge clk) disable iff (!arst_n)
        rs_ready == exp_ready)
        else value_error("rs_ready_o", 64'($sampled(exp_ready)), 64'($sampled(rs_ready)));
    // Empty system, issue two edges after acceptance
    a_latency : assert property (@(posedge clk) disable iff (!arst_n)
        (lat_arm && rs_ready && rs_valid != '0) |=> (!iss_valid ##1 iss_valid))
        else abort_run("single instruction did not issue two cycles after acceptance");

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic abort_run(input string why);
        $display("%s (time %0t)", why, $time);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string sig, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        $display("ERR time %0t signal %s expected %0h actual %0h", $time, sig, exp_v, act_v);
        abort_run("value check failed");
    endtask

    // Edge plus drive delay, then the issue-side ready with long stalls
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = $random(seed);
        if (ready_hold) begin
            iss_ready = 1'b1;
        end else if (stall_left > 0) begin
            iss_ready = 1'b0;
            stall_left--;
        end else begin
            if (r[5:0] == 6'd0) begin
                stall_left = 16 + int'(r[10:6]);
            end
            iss_ready = r[12] | r[13];
        end
    endtask

    // One slot, one-hot class, tags consecutive over valid slots
    task automatic fill_slot(input int s, input logic valid);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        rs_valid[s] = valid;
        rs_alu[s]   = valid & ~r1[2];
        rs_mult[s]  = valid & r1[2];
        rs_inst[s]  = {next_tag, r1[15:8], r1[21:16], r2[12:0], r2[25:13]};
        if (valid) begin
            next_tag = next_tag + SEQ_W'(1);
        end
    endtask

    task automatic drive_bundle();
        logic [31:0] r;
        r = $random(seed);
        for (int s = 0; s < IS_NUM; s++) begin
            fill_slot(s, r[2*s] | r[2*s+1]);
        end
    endtask

    task automatic drive_single();
        logic [31:0] r;
        r = $random(seed);
        for (int s = 0; s < IS_NUM; s++) begin
            fill_slot(s, s == int'(r[0]));
        end
    endtask

    // Bundle held until an edge with rs_ready_o high
    task automatic wait_accept();
        int n;
        n = 0;
        next_cycle();
        while (!acc_next && n < 200) begin
            next_cycle();
            n++;
        end
        if (!acc_next) begin
            abort_run("timeout waiting for a bundle to be accepted");
        end
    endtask

    task automatic drain_queues();
        int n;
        n = 0;
        while ((alu_cnt + mult_cnt) > 0 && n < 300) begin
            next_cycle();
            n++;
        end
        if ((alu_cnt + mult_cnt) > 0) begin
            abort_run("timeout waiting for the model queues to drain");
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        seed       = 32'h58595c16;
        next_tag   = '0;
        stall_left = 0;
        ready_hold = 1'b1;
        lat_arm    = 1'b0;
        arst_n     = 1'b0;
        rs_valid   = '0;
        rs_alu     = '0;
        rs_mult    = '0;
        rs_inst    = '0;
        iss_ready  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3) next_cycle();
        // Random traffic under random back-pressure
        ready_hold = 1'b0;
        for (int b = 0; b < 400; b++) begin
            drive_bundle();
            wait_accept();
        end
        rs_valid   = '0;
        rs_alu     = '0;
        rs_mult    = '0;
        ready_hold = 1'b1;
        drain_queues();
        // Lone instructions into an empty system
        for (int p = 0; p < 4; p++) begin
            lat_arm = 1'b1;
            drive_single();
            wait_accept();
            lat_arm  = 1'b0;
            rs_valid = '0;
            rs_alu   = '0;
            rs_mult  = '0;
            drain_queues();
        end
        if (alu_q.size() == 0 && mult_q.size() == 0 && !iss_valid) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("instructions left over at the end of the run");
        end
    end

endmodule : tb_ib_top

`default_nettype wire

// File: compile.f
hw/ib_cfg_pkg.sv
hw/ib_inst_pkg.sv
hw/ib_push_router.sv
hw/ib_queue.sv
hw/ib_issue_arbiter.sv
hw/ib_top.sv
tests/tb_ib_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the issue-buffer testbench with Verilator and run it
# A failed build or a failed run both leave the fail message in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_ib_top \
    -f compile.f -o sim_tb > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1 \
    || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
